//--- Makefile
.PHONY: sim clean

# build and run the fetch stage testbench, the log decides pass or fail
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module fetch_tb -f files.f -o fetch_tb_sim
	./obj_dir/fetch_tb_sim > sim.log 2>&1; cat sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
logic/core_pkg.sv
logic/bus_pkg.sv
logic/fetch_bus_requester.sv
logic/pc_redirect_unit.sv
logic/inst_aligner.sv
logic/fetch_stage.sv
verif/fetch_clock_gen.sv
verif/fetch_mem_model.sv
verif/fetch_tb.sv

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int unsigned ADDR_W = 64;
    localparam int unsigned DATA_W = 64;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] beat_t;

    // size code carried by every instruction read
    localparam logic [7:0] READ_SIZE = 8'h0F;

    // requester phases: issue, address handshake, data handshake
    typedef enum logic [1:0] {
        REQ_IDLE = 2'd0,
        REQ_ADDR = 2'd1,
        REQ_DATA = 2'd2
    } req_state_t;

endpackage

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // architectural widths of the core
    localparam int unsigned XLEN = 64;
    localparam int unsigned ILEN = 32;

    // program counter and general address value
    typedef logic [XLEN-1:0] pc_t;

    // one uncompressed instruction word
    typedef logic [ILEN-1:0] inst_t;

    // first fetch address after reset
    localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;

    // sequential advance, no compressed instructions
    localparam pc_t INST_STEP = 64'd4;

endpackage

`default_nettype wire

//--- logic/fetch_bus_requester.sv
`default_nettype none

module fetch_bus_requester (
    input  wire                logic clk,
    input  wire                logic reset_i,
    input  wire core_pkg::pc_t       cur_pc_i,

    // read address channel
    output logic                     rd_addr_valid_o,
    output bus_pkg::addr_t           rd_addr_o,
    output logic [7:0]               rd_size_o,
    input  wire                logic rd_addr_ready_i,

    // read data channel
    input  wire                logic rd_data_valid_i,
    input  wire bus_pkg::beat_t      rd_data_i,
    output logic                     rd_data_ready_o,

    // one-cycle response towards the aligner
    output logic                     resp_valid_o,
    output bus_pkg::addr_t           resp_addr_o,
    output bus_pkg::beat_t           resp_data_o
);

    bus_pkg::req_state_t state_q;

    logic           addr_valid_q;
    logic           data_ready_q;
    logic           resp_valid_q;
    bus_pkg::addr_t addr_q;
    bus_pkg::addr_t resp_addr_q;
    bus_pkg::beat_t resp_data_q;

    logic addr_fire;
    logic data_fire;

    assign addr_fire = addr_valid_q && rd_addr_ready_i;
    assign data_fire = data_ready_q && rd_data_valid_i;

    // one request in flight, idle -> addr -> data -> idle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= bus_pkg::REQ_IDLE;
            addr_valid_q <= 1'b0;
            data_ready_q <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                bus_pkg::REQ_IDLE: begin
                    state_q      <= bus_pkg::REQ_ADDR;
                    addr_valid_q <= 1'b1;
                end
                bus_pkg::REQ_ADDR: begin
                    // hold address until the slave takes it
                    if (addr_fire) begin
                        state_q      <= bus_pkg::REQ_DATA;
                        addr_valid_q <= 1'b0;
                        data_ready_q <= 1'b1;
                    end
                end
                bus_pkg::REQ_DATA: begin
                    if (data_fire) begin
                        state_q      <= bus_pkg::REQ_IDLE;
                        data_ready_q <= 1'b0;
                        resp_valid_q <= 1'b1;
                    end
                end
                default: begin
                    state_q      <= bus_pkg::REQ_IDLE;
                    addr_valid_q <= 1'b0;
                    data_ready_q <= 1'b0;
                end
            endcase
        end
    end

    // request address snapshot and response payload
    always_ff @(posedge clk) begin
        if (state_q == bus_pkg::REQ_IDLE) begin
            addr_q <= cur_pc_i;
        end
        // every beat goes on, stale or not, the aligner decides
        if (data_fire) begin
            resp_addr_q <= addr_q;
            resp_data_q <= rd_data_i;
        end
    end

    assign rd_addr_valid_o = addr_valid_q;
    assign rd_addr_o       = addr_q;
    assign rd_size_o       = bus_pkg::READ_SIZE;
    assign rd_data_ready_o = data_ready_q;

    assign resp_valid_o = resp_valid_q;
    assign resp_addr_o  = resp_addr_q;
    assign resp_data_o  = resp_data_q;

    // address channel must not change under a pending handshake
    a_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
        (rd_addr_valid_o && !rd_addr_ready_i) |=> (rd_addr_valid_o && $stable(rd_addr_o)));

    // no data accepted before the address has gone out
    a_no_ready_in_addr: assert property (@(posedge clk) disable iff (reset_i)
        (state_q == bus_pkg::REQ_ADDR) |-> !rd_data_ready_o);

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  wire                logic clk,
    input  wire                logic reset_i,

    // instruction read bus
    output logic                     rd_addr_valid_o,
    output bus_pkg::addr_t           rd_addr_o,
    output logic [7:0]               rd_size_o,
    input  wire                logic rd_addr_ready_i,
    input  wire                logic rd_data_valid_i,
    input  wire bus_pkg::beat_t      rd_data_i,
    output logic                     rd_data_ready_o,

    // redirect sources
    input  wire                logic me_jal_i,
    input  wire                logic me_jalr_i,
    input  wire                logic me_branch_i,
    input  wire core_pkg::pc_t       me_alu_res_i,
    input  wire core_pkg::pc_t       me_pc_i,
    input  wire core_pkg::pc_t       me_imm_i,
    input  wire core_pkg::pc_t       me_rs1_data_i,
    input  wire                logic trap_i,
    input  wire core_pkg::pc_t       trap_vector_i,
    input  wire                logic stall_i,

    // to decode
    output core_pkg::inst_t          inst_o,
    output core_pkg::pc_t            inst_pc_o,
    output logic                     inst_valid_o
);

    core_pkg::pc_t  cur_pc;
    logic           resp_valid;
    bus_pkg::addr_t resp_addr;
    bus_pkg::beat_t resp_data;
    logic           delivered;

    fetch_bus_requester requester_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .cur_pc_i        (cur_pc),
        .rd_addr_valid_o (rd_addr_valid_o),
        .rd_addr_o       (rd_addr_o),
        .rd_size_o       (rd_size_o),
        .rd_addr_ready_i (rd_addr_ready_i),
        .rd_data_valid_i (rd_data_valid_i),
        .rd_data_i       (rd_data_i),
        .rd_data_ready_o (rd_data_ready_o),
        .resp_valid_o    (resp_valid),
        .resp_addr_o     (resp_addr),
        .resp_data_o     (resp_data)
    );

    pc_redirect_unit redirect_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .me_jal_i      (me_jal_i),
        .me_jalr_i     (me_jalr_i),
        .me_branch_i   (me_branch_i),
        .me_alu_res_i  (me_alu_res_i),
        .me_pc_i       (me_pc_i),
        .me_imm_i      (me_imm_i),
        .me_rs1_data_i (me_rs1_data_i),
        .trap_i        (trap_i),
        .trap_vector_i (trap_vector_i),
        .stall_i       (stall_i),
        .delivered_i   (delivered),
        .cur_pc_o      (cur_pc)
    );

    inst_aligner aligner_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .cur_pc_i     (cur_pc),
        .resp_valid_i (resp_valid),
        .resp_addr_i  (resp_addr),
        .resp_data_i  (resp_data),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_valid_o (inst_valid_o),
        .delivered_o  (delivered)
    );

endmodule

`default_nettype wire

//--- logic/inst_aligner.sv
`default_nettype none

module inst_aligner (
    input  wire                logic clk,
    input  wire                logic reset_i,
    input  wire core_pkg::pc_t       cur_pc_i,

    // response from the bus requester
    input  wire                logic resp_valid_i,
    input  wire bus_pkg::addr_t      resp_addr_i,
    input  wire bus_pkg::beat_t      resp_data_i,

    output core_pkg::inst_t          inst_o,
    output core_pkg::pc_t            inst_pc_o,
    output logic                     inst_valid_o,
    output logic                     delivered_o
);

    core_pkg::inst_t inst_q;
    logic            inst_valid_q;

    // pc of the last instruction handed out
    core_pkg::pc_t inst_pc_q;
    logic          delivered_q;

    logic            accept;
    core_pkg::inst_t word;

    // only a response for the live pc, and only once
    assign accept = resp_valid_i && (resp_addr_i == cur_pc_i) && !delivered_o;

    // bit 2 picks the half of the 64-bit beat
    assign word = resp_addr_i[2] ? resp_data_i[63:32] : resp_data_i[31:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_valid_q <= 1'b0;
            delivered_q  <= 1'b0;
        end else begin
            inst_valid_q <= accept;
            if (accept) begin
                delivered_q <= 1'b1;
            end else if (inst_pc_q != cur_pc_i) begin
                delivered_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q    <= word;
            inst_pc_q <= cur_pc_i;
        end
    end

    // drops in the same cycle the pc moves away
    assign delivered_o = delivered_q && (inst_pc_q == cur_pc_i);

    assign inst_o       = inst_q;
    assign inst_pc_o    = inst_pc_q;
    assign inst_valid_o = inst_valid_q;

endmodule

`default_nettype wire

//--- logic/pc_redirect_unit.sv
`default_nettype none

module pc_redirect_unit (
    input  wire                logic clk,
    input  wire                logic reset_i,

    // resolved control flow from the memory stage
    input  wire                logic me_jal_i,
    input  wire                logic me_jalr_i,
    input  wire                logic me_branch_i,
    input  wire core_pkg::pc_t       me_alu_res_i,
    input  wire core_pkg::pc_t       me_pc_i,
    input  wire core_pkg::pc_t       me_imm_i,
    input  wire core_pkg::pc_t       me_rs1_data_i,

    // exception entry
    input  wire                logic trap_i,
    input  wire core_pkg::pc_t       trap_vector_i,

    input  wire                logic stall_i,
    input  wire                logic delivered_i,

    output core_pkg::pc_t            cur_pc_o
);

    core_pkg::pc_t pc_q;
    core_pkg::pc_t pc_d;
    core_pkg::pc_t jalr_sum;

    logic take_jump;
    logic redirect;
    logic seq_step;

    // branch compare result of zero means taken
    assign take_jump = me_jal_i || (me_branch_i && (me_alu_res_i == '0));
    assign jalr_sum  = me_rs1_data_i + me_imm_i;
    assign redirect  = take_jump || me_jalr_i || trap_i;

    // advance only once the current instruction went out
    assign seq_step = delivered_i && !stall_i;

    always_comb begin
        if (take_jump) begin
            pc_d = me_pc_i + me_imm_i;
        end else if (me_jalr_i) begin
            // jalr target has bit 0 forced low
            pc_d = jalr_sum & ~core_pkg::pc_t'(1);
        end else if (trap_i) begin
            pc_d = trap_vector_i;
        end else if (seq_step) begin
            pc_d = pc_q + core_pkg::INST_STEP;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= core_pkg::RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign cur_pc_o = pc_q;

    // sequential flow never produces a misaligned pc
    a_seq_aligned: assert property (@(posedge clk) disable iff (reset_i)
        (seq_step && !redirect) |=> (cur_pc_o[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- verif/fetch_clock_gen.sv
`default_nettype none

module fetch_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // two rising edges in reset, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/fetch_mem_model.sv
`default_nettype none

module fetch_mem_model (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           rd_addr_valid_i,
    input  wire bus_pkg::addr_t rd_addr_i,
    output logic                rd_addr_ready_o,
    output logic                rd_data_valid_o,
    output bus_pkg::beat_t      rd_data_o,
    input  wire logic           rd_data_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    integer         seed = 32'ha299;
    logic [31:0]    rnd;
    logic [1:0]     phase = 2'd0;
    logic [1:0]     delay = 2'd0;
    logic           addr_ready = 1'b0;
    logic           data_valid = 1'b0;
    bus_pkg::beat_t data = '0;
    bus_pkg::addr_t base = '0;

    // handshakes as the DUT sees them on the rising edge
    logic           rst_q = 1'b1;
    logic           addr_fire_q = 1'b0;
    logic           data_fire_q = 1'b0;
    bus_pkg::addr_t req_addr = '0;

    // memory content of one 32-bit word
    function automatic logic [31:0] word_at(input bus_pkg::addr_t a);
        return a[31:0] ^ 32'h5A5A_5A5A;
    endfunction

    always @(posedge clk) begin
        rst_q       <= reset_i;
        addr_fire_q <= rd_addr_valid_i && addr_ready && !reset_i;
        data_fire_q <= data_valid && rd_data_ready_i && !reset_i;
        if (rd_addr_valid_i && addr_ready) begin
            req_addr <= rd_addr_i;
        end
    end

    // phase 0 takes the address, 1 waits out the latency, 2 offers the beat
    always @(negedge clk) begin
        rnd = $random(seed);
        if (rst_q) begin
            phase      = 2'd0;
            addr_ready = 1'b0;
            data_valid = 1'b0;
        end else begin
            case (phase)
                2'd0: begin
                    if (addr_fire_q) begin
                        addr_ready = 1'b0;
                        delay      = rnd[3:2];
                        phase      = 2'd1;
                    end else begin
                        addr_ready = (rnd[1:0] != 2'b00);
                    end
                end
                2'd1: begin
                    if (delay == 2'd0) begin
                        base       = {req_addr[63:3], 3'b000};
                        data       = {word_at(base + 64'd4), word_at(base)};
                        data_valid = 1'b1;
                        phase      = 2'd2;
                    end else begin
                        delay = delay - 2'd1;
                    end
                end
                default: begin
                    if (data_fire_q) begin
                        data_valid = 1'b0;
                        phase      = 2'd0;
                    end
                end
            endcase
        end
    end

    assign rd_addr_ready_o = addr_ready;
    assign rd_data_valid_o = data_valid;
    assign rd_data_o       = data;

endmodule

`default_nettype wire

//--- verif/fetch_tb.sv
`default_nettype none

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // action taken in the cycle that follows each delivery
    typedef enum int {
        STEP_SEQ, STEP_JAL, STEP_BR_TAKEN, STEP_BR_NOT_TAKEN, STEP_JALR_ODD,
        STEP_JAL_JALR, STEP_TRAP, STEP_TRAP_JALR, STEP_STALL, STEP_LATE_JAL
    } step_t;

    localparam int N_STEPS = 14;
    localparam int CYCLES_PER_INST = 200;

    step_t steps [N_STEPS] = '{
        STEP_SEQ, STEP_SEQ, STEP_SEQ, STEP_JAL, STEP_BR_TAKEN, STEP_BR_NOT_TAKEN,
        STEP_JALR_ODD, STEP_JAL_JALR, STEP_TRAP, STEP_TRAP_JALR, STEP_STALL,
        STEP_SEQ, STEP_LATE_JAL, STEP_SEQ
    };

    logic clk;
    logic reset;

    logic           rd_addr_valid;
    bus_pkg::addr_t rd_addr;
    logic [7:0]     rd_size;
    logic           rd_addr_ready;
    logic           rd_data_valid;
    bus_pkg::beat_t rd_data;
    logic           rd_data_ready;

    logic            me_jal, me_jalr, me_branch, trap, stall;
    core_pkg::pc_t   me_alu_res, me_pc, me_imm, me_rs1_data, trap_vector;
    core_pkg::inst_t inst;
    core_pkg::pc_t   inst_pc;
    logic            inst_valid;

    // expected delivery order, written by stimulus and read by the monitor
    core_pkg::pc_t exp_pcs [N_STEPS + 1];
    int            n_exp = 0;
    int            n_seen = 0;
    core_pkg::pc_t model_pc;
    core_pkg::pc_t pending_pc;

    fetch_clock_gen clkgen_i (.clk_o(clk), .reset_o(reset));

    fetch_mem_model mem_i (
        .clk(clk), .reset_i(reset),
        .rd_addr_valid_i(rd_addr_valid), .rd_addr_i(rd_addr), .rd_addr_ready_o(rd_addr_ready),
        .rd_data_valid_o(rd_data_valid), .rd_data_o(rd_data), .rd_data_ready_i(rd_data_ready)
    );

    fetch_stage dut_i (
        .clk(clk), .reset_i(reset),
        .rd_addr_valid_o(rd_addr_valid), .rd_addr_o(rd_addr), .rd_size_o(rd_size),
        .rd_addr_ready_i(rd_addr_ready), .rd_data_valid_i(rd_data_valid),
        .rd_data_i(rd_data), .rd_data_ready_o(rd_data_ready),
        .me_jal_i(me_jal), .me_jalr_i(me_jalr), .me_branch_i(me_branch),
        .me_alu_res_i(me_alu_res), .me_pc_i(me_pc), .me_imm_i(me_imm),
        .me_rs1_data_i(me_rs1_data), .trap_i(trap), .trap_vector_i(trap_vector),
        .stall_i(stall), .inst_o(inst), .inst_pc_o(inst_pc), .inst_valid_o(inst_valid)
    );

    // redirect priority: jal or taken branch, then jalr, then trap, then pc+4
    function automatic core_pkg::pc_t exp_next_pc(input core_pkg::pc_t pc,
            input logic jal, input logic jalr, input logic branch, input logic trp,
            input core_pkg::pc_t alu, input core_pkg::pc_t mpc, input core_pkg::pc_t imm,
            input core_pkg::pc_t rs1, input core_pkg::pc_t tvec);
        if (jal || (branch && alu == '0)) begin
            return mpc + imm;
        end else if (jalr) begin
            return (rs1 + imm) & ~64'd1;
        end else if (trp) begin
            return tvec;
        end
        return pc + 64'd4;
    endfunction

    function automatic core_pkg::inst_t exp_inst(input core_pkg::pc_t pc);
        return pc[31:0] ^ 32'h5A5A_5A5A;
    endfunction

    task automatic check_pc(input string name, input core_pkg::pc_t got,
            input core_pkg::pc_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_inst(input string name, input core_pkg::inst_t got,
            input core_pkg::inst_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_size(input string name, input logic [7:0] got,
            input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic push_expected(input core_pkg::pc_t pc);
        exp_pcs[n_exp] = pc;
        n_exp++;
        model_pc = pc;
    endtask

    task automatic clear_redirect();
        me_jal      = 1'b0;
        me_jalr     = 1'b0;
        me_branch   = 1'b0;
        trap        = 1'b0;
        me_alu_res  = '0;
        me_pc       = '0;
        me_imm      = '0;
        me_rs1_data = '0;
        trap_vector = '0;
    endtask

    // one-cycle pulse on the redirect inputs
    task automatic drive_redirect(input logic jal, input logic jalr, input logic branch,
            input logic trp, input core_pkg::pc_t alu, input core_pkg::pc_t mpc,
            input core_pkg::pc_t imm, input core_pkg::pc_t rs1, input core_pkg::pc_t tvec);
        me_jal      = jal;
        me_jalr     = jalr;
        me_branch   = branch;
        trap        = trp;
        me_alu_res  = alu;
        me_pc       = mpc;
        me_imm      = imm;
        me_rs1_data = rs1;
        trap_vector = tvec;
        push_expected(exp_next_pc(model_pc, jal, jalr, branch, trp, alu, mpc, imm, rs1, tvec));
        @(negedge clk);
        clear_redirect();
    endtask

    task automatic hold_stall(input int n);
        stall = 1'b1;
        push_expected(exp_next_pc(model_pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0, '0, '0));
        repeat (n) @(negedge clk);
        stall = 1'b0;
    endtask

    task automatic wait_delivery();
        do @(negedge clk); while (inst_valid !== 1'b1);
    endtask

    // address accepted, beat still outstanding
    task automatic wait_in_flight(input core_pkg::pc_t addr);
        do @(negedge clk); while (!(rd_data_ready === 1'b1 && rd_addr === addr));
    endtask

    task automatic run_step(input step_t kind);
        case (kind)
            STEP_JAL: drive_redirect(1'b1, 1'b0, 1'b0, 1'b0, '0, model_pc, 64'h100, '0, '0);
            STEP_BR_TAKEN: drive_redirect(1'b0, 1'b0, 1'b1, 1'b0, '0, model_pc,
                64'hFFFF_FFFF_FFFF_FFC0, '0, '0);
            STEP_BR_NOT_TAKEN: drive_redirect(1'b0, 1'b0, 1'b1, 1'b0, 64'd1, model_pc,
                64'h200, '0, '0);
            STEP_JALR_ODD: drive_redirect(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, 64'hE,
                64'h8000_2003, '0);
            STEP_JAL_JALR: drive_redirect(1'b1, 1'b1, 1'b0, 1'b0, '0, model_pc, 64'h24,
                64'h8000_4001, '0);
            STEP_TRAP: drive_redirect(1'b0, 1'b0, 1'b0, 1'b1, '0, '0, '0, '0, 64'h8000_0800);
            STEP_TRAP_JALR: drive_redirect(1'b0, 1'b1, 1'b0, 1'b1, '0, '0, 64'h4,
                64'h8000_3005, 64'h8000_0800);
            STEP_STALL: hold_stall(30);
            STEP_LATE_JAL: begin
                // redirect lands while the fetch of pc+4 waits for its beat
                pending_pc = exp_next_pc(model_pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0, '0, '0);
                wait_in_flight(pending_pc);
                model_pc = pending_pc;
                drive_redirect(1'b1, 1'b0, 1'b0, 1'b0, '0, 64'h8000_1000, 64'h14, '0, '0);
            end
            default: drive_redirect(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0, '0, '0);
        endcase
    endtask

    // compare every delivered instruction with the expected order
    always @(negedge clk) begin
        if (reset === 1'b0 && inst_valid === 1'b1) begin
            if (n_seen >= n_exp) begin
                $display("instruction at pc %h was delivered while none was expected", inst_pc);
                $display("Simulation FAILED");
                $fatal(1);
            end else begin
                check_pc("inst_pc_o", inst_pc, exp_pcs[n_seen]);
                check_inst("inst_o", inst, exp_inst(exp_pcs[n_seen]));
                n_seen++;
            end
        end
    end

    always @(negedge clk) begin
        if (reset === 1'b0 && rd_addr_valid === 1'b1) begin
            check_size("rd_size_o", rd_size, 8'h0F);
        end
    end

    initial begin
        repeat ((N_STEPS + 1) * CYCLES_PER_INST) @(posedge clk);
        $display("timeout: the fetch stage stopped delivering instructions");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        clear_redirect();
        stall = 1'b0;
        push_expected(64'h0000_0000_8000_0000);
        wait (reset === 1'b0);
        for (int i = 0; i < N_STEPS; i++) begin
            wait_delivery();
            run_step(steps[i]);
        end
        wait_delivery();
        // park on the last pc, repeats must all be dropped
        stall = 1'b1;
        repeat (40) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
